// File: hw/deck_defines.svh
/*
 * Deck sizing constants shared by the package and the RTL.
 * DECK_IDX_W must hold DECK_SIZE, and LFSR_W must equal DECK_IDX_W
 * because the random value is used directly as a card index.
 */
`ifndef DECK_DEFINES_SVH
`define DECK_DEFINES_SVH

`define DECK_SIZE       108 // four colours of 27 cards
`define DECK_IDX_W      7   // card index and card count
`define LFSR_W          7   // random index width

// at or above this count an inserted card lands at a random position
`define INSERT_RAND_MIN 20

`endif

// File: hw/card_deck_pkg.sv
/*
 * Card encoding and the controller-to-store operation word.
 * A card is 6 bits with colour above value.
 * The operation indices are DECK_IDX_W bits wide.
 */
`include "deck_defines.svh"

package card_deck_pkg;

    typedef enum logic [1:0] {
        RED    = 2'd0,
        YELLOW = 2'd1,
        GREEN  = 2'd2,
        BLUE   = 2'd3
    } card_color_t;

    // 0 to 9 are number cards
    typedef enum logic [3:0] {
        VAL_0 = 4'd0, VAL_1 = 4'd1, VAL_2 = 4'd2, VAL_3 = 4'd3, VAL_4 = 4'd4,
        VAL_5 = 4'd5, VAL_6 = 4'd6, VAL_7 = 4'd7, VAL_8 = 4'd8, VAL_9 = 4'd9,
        VAL_SKIP           = 4'd10,
        VAL_REVERSE        = 4'd11,
        VAL_DRAW_TWO       = 4'd12,
        VAL_WILD           = 4'd13,
        VAL_WILD_DRAW_FOUR = 4'd14
    } card_value_t;

    typedef struct packed {
        card_color_t color;
        card_value_t value;
    } card_t;

    // one-hot request size
    typedef struct packed {
        logic four;
        logic two;
        logic one;
    } draw_count_t;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_SWAP  = 2'd1, // exchange a and b
        OP_PLACE = 2'd2, // b moves to a, card goes to b
        OP_WRITE = 2'd3  // card goes to a
    } store_op_kind_t;

    typedef struct packed {
        store_op_kind_t          kind;
        logic [`DECK_IDX_W-1:0]  idx_a;
        logic [`DECK_IDX_W-1:0]  idx_b;
        card_t                   card;
    } store_op_t;

endpackage

// File: hw/deck_lfsr.sv
/*
 * Random index source. A free-running counter is sampled on i_seed,
 * so the seed depends on when the request came. A zero seed becomes 1.
 * The LFSR never produces 0.
 */
`include "deck_defines.svh"

module deck_lfsr (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_seed,
    output logic [`LFSR_W-1:0]   o_rand
);

    logic [`LFSR_W-1:0] seed_cnt;
    logic [`LFSR_W-1:0] lfsr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seed_cnt <= '0;
            lfsr     <= `LFSR_W'(1); // any nonzero start
        end else begin
            seed_cnt <= seed_cnt + 1'b1; // entropy from request timing
            if (i_seed) begin
                lfsr <= (seed_cnt == '0) ? `LFSR_W'(1) : seed_cnt; // keep out of lockup
            end else begin
                lfsr <= {lfsr[3] ^ lfsr[0], lfsr[`LFSR_W-1:1]}; // x^7 + x^4 + 1
            end
        end
    end

    assign o_rand = lfsr;

endmodule

// File: hw/deck_store.sv
/*
 * 108-card register array. i_init loads the reference order and wins
 * over any operation in the same cycle. Operations land at the next edge.
 * Indices must stay below DECK_SIZE; an out-of-range read returns red 0.
 */
`include "deck_defines.svh"

module deck_store (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_init,
    input  card_deck_pkg::store_op_t    i_op,
    input  logic [`DECK_IDX_W-1:0]      i_rd_idx,
    output card_deck_pkg::card_t        o_rd_card
);

    localparam card_deck_pkg::card_t BLANK = '{
        color: card_deck_pkg::RED,
        value: card_deck_pkg::VAL_0
    };

    card_deck_pkg::card_t mem [`DECK_SIZE];

    // reference order: 27 cards per colour, red first
    function automatic card_deck_pkg::card_t init_card(input int idx);
        int k;
        int v;
        card_deck_pkg::card_t c;
        k = idx % 27;
        if (k == 0) begin
            v = 0; // single zero
        end else if (k <= 24) begin
            v = (k + 1) / 2; // pairs of 1..9, skip, reverse, draw two
        end else begin
            v = k - 12; // wild, then wild draw four
        end
        c.color = card_deck_pkg::card_color_t'(2'(idx / 27));
        c.value = card_deck_pkg::card_value_t'(4'(v));
        return c;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `DECK_SIZE; i++) begin
                mem[i] <= BLANK;
            end
        end else if (i_init) begin
            for (int i = 0; i < `DECK_SIZE; i++) begin
                mem[i] <= init_card(i);
            end
        end else begin
            case (i_op.kind)
                card_deck_pkg::OP_SWAP: begin
                    mem[i_op.idx_a] <= mem[i_op.idx_b];
                    mem[i_op.idx_b] <= mem[i_op.idx_a];
                end
                card_deck_pkg::OP_PLACE: begin
                    mem[i_op.idx_a] <= mem[i_op.idx_b];
                    mem[i_op.idx_b] <= i_op.card; // last write wins when a == b
                end
                card_deck_pkg::OP_WRITE: begin
                    mem[i_op.idx_a] <= i_op.card;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        if (i_rd_idx < `DECK_IDX_W'(`DECK_SIZE)) begin
            o_rd_card = mem[i_rd_idx];
        end else begin
            o_rd_card = BLANK; // empty deck reads index 127
        end
    end

endmodule

// File: hw/deck_ctrl.sv
/*
 * Deck controller. Requests are taken only in idle, with priority
 * start, insert, draw. Start reshuffles all 108 entries and restores the
 * count. Inserts into a full deck are dropped; deals cannot be stalled.
 */
`include "deck_defines.svh"

module deck_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  logic                        i_draw,
    input  card_deck_pkg::draw_count_t  i_draw_cnt,
    input  logic                        i_insert,
    input  card_deck_pkg::card_t        i_prev_card,
    input  logic [`LFSR_W-1:0]          i_rand,
    output logic                        o_init,
    output card_deck_pkg::store_op_t    o_op,
    output logic [`DECK_IDX_W-1:0]      o_rd_idx,
    output logic                        o_done,
    output logic                        o_drawn,
    output logic [`DECK_IDX_W-1:0]      o_count
);

    localparam logic [`DECK_IDX_W-1:0] FULL     = `DECK_IDX_W'(`DECK_SIZE);
    localparam logic [`DECK_IDX_W-1:0] TOP_IDX  = `DECK_IDX_W'(`DECK_SIZE - 1);
    localparam logic [`DECK_IDX_W-1:0] RAND_MIN = `DECK_IDX_W'(`INSERT_RAND_MIN);

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_SHUFFLE,
        S_DEAL_STROBE,
        S_DEAL_STEP,
        S_INSERT
    } state_t;

    state_t                  state;
    logic [`DECK_IDX_W-1:0]  count;
    logic [`DECK_IDX_W-1:0]  shuf_idx;
    logic [2:0]              deal_left;
    card_deck_pkg::card_t    ins_card;
    logic [2:0]              req_cnt;
    logic                    swap_ok;
    logic                    ins_on_top;
    logic                    ins_ok;

    always_comb begin
        if (i_draw_cnt.four) begin
            req_cnt = 3'd4;
        end else if (i_draw_cnt.two) begin
            req_cnt = 3'd2;
        end else begin
            req_cnt = 3'd1; // one, or no bit set
        end
    end

    assign swap_ok    = (i_rand <= shuf_idx); // otherwise retry same index
    assign ins_on_top = (count < RAND_MIN);
    assign ins_ok     = ins_on_top || (i_rand <= count);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_INIT;
            count     <= '0;
            shuf_idx  <= '0;
            deal_left <= '0;
        end else begin
            case (state)
                S_INIT: begin
                    count <= FULL; // store fills on this edge
                    state <= S_IDLE;
                end
                S_IDLE: begin
                    if (i_start) begin
                        shuf_idx <= TOP_IDX;
                        count    <= FULL; // dealt cards are still in the array
                        state    <= S_SHUFFLE;
                    end else if (i_insert) begin
                        if (count != FULL) begin
                            state <= S_INSERT;
                        end
                    end else if (i_draw) begin
                        deal_left <= req_cnt;
                        state     <= S_DEAL_STROBE;
                    end
                end
                S_SHUFFLE: begin
                    if (swap_ok) begin
                        shuf_idx <= shuf_idx - 1'b1;
                        if (shuf_idx == `DECK_IDX_W'(1)) begin
                            state <= S_IDLE;
                        end
                    end
                end
                S_DEAL_STROBE: begin
                    state <= (count == '0) ? S_IDLE : S_DEAL_STEP;
                end
                S_DEAL_STEP: begin
                    count     <= count - 1'b1;
                    deal_left <= deal_left - 1'b1;
                    if (deal_left == 3'd1 || count == `DECK_IDX_W'(1)) begin
                        state <= S_IDLE;
                    end else begin
                        state <= S_DEAL_STROBE;
                    end
                end
                S_INSERT: begin
                    if (ins_ok) begin
                        count <= count + 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // card to insert, held while waiting for a usable random value
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_insert) begin
            ins_card <= i_prev_card;
        end
    end

    always_comb begin
        o_op.kind  = card_deck_pkg::OP_NONE;
        o_op.idx_a = count;
        o_op.idx_b = i_rand;
        o_op.card  = ins_card;
        case (state)
            S_SHUFFLE: begin
                if (swap_ok) begin
                    o_op.kind  = card_deck_pkg::OP_SWAP;
                    o_op.idx_a = shuf_idx;
                end
            end
            S_INSERT: begin
                if (ins_on_top) begin
                    o_op.kind = card_deck_pkg::OP_WRITE; // new top at index count
                end else if (ins_ok) begin
                    o_op.kind = card_deck_pkg::OP_PLACE; // displaced card to top
                end
            end
            default: begin
            end
        endcase
    end

    assign o_init   = (state == S_INIT);
    assign o_done   = (state == S_IDLE);
    assign o_drawn  = (state == S_DEAL_STROBE) && (count != '0);
    assign o_rd_idx = count - 1'b1; // top card
    assign o_count  = count;

endmodule

// File: hw/card_deck.sv
/*
 * Card deck engine top. Start, draw and insert are one-cycle pulses
 * taken only while o_done is high. Each dealt card is valid for the
 * single cycle of o_drawn; there is no back-pressure.
 */
`include "deck_defines.svh"

module card_deck (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  logic                        i_draw,
    input  card_deck_pkg::draw_count_t  i_draw_cnt,
    input  logic                        i_insert,
    input  card_deck_pkg::card_t        i_prev_card,
    output logic                        o_done,
    output logic                        o_drawn,
    output card_deck_pkg::card_t        o_card,
    output logic [`DECK_IDX_W-1:0]      o_count
);

    logic                      store_init;
    card_deck_pkg::store_op_t  store_op;
    logic [`DECK_IDX_W-1:0]    rd_idx;
    logic [`LFSR_W-1:0]        rand_val;

    deck_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_draw      (i_draw),
        .i_draw_cnt  (i_draw_cnt),
        .i_insert    (i_insert),
        .i_prev_card (i_prev_card),
        .i_rand      (rand_val),
        .o_init      (store_init),
        .o_op        (store_op),
        .o_rd_idx    (rd_idx),
        .o_done      (o_done),
        .o_drawn     (o_drawn),
        .o_count     (o_count)
    );

    deck_store u_store (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_init    (store_init),
        .i_op      (store_op),
        .i_rd_idx  (rd_idx),
        .o_rd_card (o_card)
    );

    deck_lfsr u_lfsr (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_seed  (i_start), // reseed on every start pulse
        .o_rand  (rand_val)
    );

endmodule

// File: dv/tb_card_deck.sv
/*
 * Directed testbench for the card deck engine. Inputs change 2 ns after
 * the rising edge and outputs are sampled on the falling edge.
 * Expected decks come from a model of the reference fill order.
 */
`include "deck_defines.svh"

module tb_card_deck;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT = 20000; // cycles, covers the longest shuffle
    localparam logic [31:0] SEED    = 32'ha42a0e72;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic                         draw;
    card_deck_pkg::draw_count_t   draw_cnt;
    logic                         insert;
    card_deck_pkg::card_t         prev_card;
    logic                         done;
    logic                         drawn;
    card_deck_pkg::card_t         card;
    logic [`DECK_IDX_W-1:0]       count;

    card_deck_pkg::card_t ref_deck[$]; // reference order, index 0 at the bottom
    card_deck_pkg::card_t dealt[$];
    int errors;
    int tests_run;
    int tests_failed;

    card_deck dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_draw      (draw),
        .i_draw_cnt  (draw_cnt),
        .i_insert    (insert),
        .i_prev_card (prev_card),
        .o_done      (done),
        .o_drawn     (drawn),
        .o_card      (card),
        .o_count     (count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic card_deck_pkg::card_t make_card(input int c, input int v);
        card_deck_pkg::card_t x;
        x.color = card_deck_pkg::card_color_t'(c[1:0]);
        x.value = card_deck_pkg::card_value_t'(v[3:0]);
        return x;
    endfunction

    // per colour: one 0, pairs of 1 to 12, one wild, one wild draw four
    function automatic void build_initial_deck();
        ref_deck.delete();
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v <= 14; v++) begin
                repeat ((v == 0 || v >= 13) ? 1 : 2) ref_deck.push_back(make_card(c, v));
            end
        end
    endfunction

    task automatic check_card(input string name, input card_deck_pkg::card_t got,
                              input card_deck_pkg::card_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %0d/%0d expected %0d/%0d", $time, name,
                     got.color, got.value, exp.color, exp.value);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [`DECK_IDX_W-1:0] got,
                               input logic [`DECK_IDX_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_multiset(input string name, input card_deck_pkg::card_t got[$],
                                  input card_deck_pkg::card_t exp[$]);
        int hist_got[64];
        int hist_exp[64];
        for (int i = 0; i < 64; i++) begin
            hist_got[i] = 0;
            hist_exp[i] = 0;
        end
        foreach (got[i]) hist_got[got[i]]++;
        foreach (exp[i]) hist_exp[exp[i]]++;
        for (int i = 0; i < 64; i++) begin
            check_count($sformatf("%s code %0d", name, i), 7'(hist_got[i]), 7'(hist_exp[i]));
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("%s: o_done stayed low for %0d cycles", what, TIMEOUT);
            errors++;
        end
    endtask

    // one-cycle request pulse with its data, launched while the controller is idle
    task automatic pulse(input logic s, input logic ins, input logic d,
                         input card_deck_pkg::draw_count_t cnt,
                         input card_deck_pkg::card_t c);
        wait_done("request");
        @(posedge clk);
        #2;
        start     = s;
        insert    = ins;
        draw      = d;
        draw_cnt  = cnt;
        prev_card = c;
        @(posedge clk);
        #2;
        start  = 1'b0;
        insert = 1'b0;
        draw   = 1'b0;
    endtask

    task automatic send_draw(input card_deck_pkg::draw_count_t cnt);
        int n;
        pulse(1'b0, 1'b0, 1'b1, cnt, prev_card);
        n = 0;
        @(negedge clk);
        while (done !== 1'b1 && n < TIMEOUT) begin
            if (drawn === 1'b1) begin
                dealt.push_back(card); // no back-pressure, take it now
            end
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("deal did not return to idle within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic send_insert(input card_deck_pkg::card_t c);
        pulse(1'b0, 1'b1, 1'b0, draw_cnt, c);
        wait_done("insert");
    endtask

    task automatic deal_all();
        int guard;
        guard = 0;
        while (count != 7'd0 && guard < 2 * `DECK_SIZE) begin
            send_draw(card_deck_pkg::draw_count_t'(3'b001 << ($urandom % 3)));
            guard++;
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int e;
        int n;
        e = errors;
        n = 0;
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("o_done was high in the fill cycle after reset");
            errors++;
        end
        while (done !== 1'b1 && n < TIMEOUT) begin
            if (drawn !== 1'b0) begin
                $display("o_drawn went high before the deck was ready");
                errors++;
            end
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("o_done never rose after reset");
            errors++;
        end
        check_count("o_count", count, 7'd108);
        end_test("reset", e);
    endtask

    task automatic test_first_deal();
        int e;
        e = errors;
        dealt.delete();
        send_draw(card_deck_pkg::draw_count_t'(3'b100));
        check_count("cards dealt", 7'(dealt.size()), 7'd4);
        for (int i = 0; i < 4 && i < dealt.size(); i++) begin
            check_card($sformatf("o_card %0d", i), dealt[i], ref_deck[107 - i]);
        end
        check_count("o_count", count, 7'd104);
        end_test("unshuffled four-card deal", e);
    endtask

    task automatic test_shuffle_deal();
        int e;
        e = errors;
        pulse(1'b1, 1'b0, 1'b0, draw_cnt, prev_card);
        wait_done("shuffle");
        check_count("o_count", count, 7'd108);
        dealt.delete();
        deal_all();
        check_count("cards dealt", 7'(dealt.size()), 7'd108);
        check_multiset("shuffled deck", dealt, ref_deck);
        check_count("o_count", count, 7'd0);
        end_test("shuffle and full deal", e);
    endtask

    task automatic test_empty_draw();
        int e;
        e = errors;
        dealt.delete();
        send_draw(card_deck_pkg::draw_count_t'(3'b001));
        check_count("cards dealt", 7'(dealt.size()), 7'd0);
        check_count("o_count", count, 7'd0);
        end_test("draw from empty deck", e);
    endtask

    task automatic test_insert_top();
        int e;
        card_deck_pkg::card_t ins;
        e = errors;
        ins = make_card(2, 7);
        send_insert(ins);
        check_count("o_count", count, 7'd1);
        dealt.delete();
        send_draw(card_deck_pkg::draw_count_t'(3'b001));
        check_count("cards dealt", 7'(dealt.size()), 7'd1);
        if (dealt.size() > 0) check_card("o_card", dealt[0], ins);
        check_count("o_count", count, 7'd0);
        end_test("insert on top", e);
    endtask

    // red 0 is unique among indices 1 to 107, so its dealt slot gives the position
    task automatic test_insert_random();
        int e;
        int r;
        card_deck_pkg::card_t ins;
        card_deck_pkg::card_t first;
        card_deck_pkg::card_t exp;
        card_deck_pkg::card_t all_got[$];
        card_deck_pkg::card_t all_exp[$];
        e = errors;
        ins = make_card(0, 0);
        reset_dut();
        wait_done("reset");
        dealt.delete();
        send_draw(card_deck_pkg::draw_count_t'(3'b001));
        first = (dealt.size() > 0) ? dealt[0] : ins;
        check_card("first o_card", first, ref_deck[107]);
        send_insert(ins);
        check_count("o_count", count, 7'd108);
        dealt.delete();
        deal_all();
        check_count("cards dealt", 7'(dealt.size()), 7'd108);
        all_got = dealt;
        all_got.push_back(first);
        all_exp = ref_deck;
        all_exp.push_back(ins);
        check_multiset("deck after insert", all_got, all_exp);
        if (dealt.size() == 108) begin
            r = 107; // card landed on top
            for (int k = 1; k <= 106; k++) begin
                if (r == 107 && dealt[k] == ins) r = 107 - k;
            end
            for (int k = 0; k < 108; k++) begin
                if (k == 0) begin
                    exp = (r == 107) ? ins : ref_deck[r]; // displaced card is on top
                end else begin
                    exp = (107 - k == r) ? ins : ref_deck[107 - k];
                end
                check_card($sformatf("o_card %0d", k), dealt[k], exp);
            end
        end
        end_test("random insert", e);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        draw      = 1'b0;
        draw_cnt  = card_deck_pkg::draw_count_t'(3'b001);
        insert    = 1'b0;
        prev_card = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        build_initial_deck();
        reset_dut();
        test_reset();
        test_first_deal();
        test_shuffle_deal();
        test_empty_draw();
        test_insert_top();
        test_insert_random();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/card_deck_pkg.sv
hw/deck_lfsr.sv
hw/deck_store.sv
hw/deck_ctrl.sv
hw/card_deck.sv
dv/tb_card_deck.sv

// File: Makefile
# Verilator build and run for the card deck testbench

SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP      = tb_card_deck
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
